// ==== clint.f ====
+incdir+logic
logic/clint_pkg.sv
logic/clint_bus_if.sv
logic/clint_arbiter.sv
logic/clint_timer.sv
logic/clint_regs.sv
logic/clint_top.sv
testbench/clint_tb.sv

// ==== testbench/clint_tb.sv ====
`include "clint_settings.svh"

module clint_tb;

  localparam int TickCycles = `CLINT_TICK_CYCLES;
  localparam int MaxCycles  = 2000;

  // addr[1:0] picks the register and addr[2] the high half
  localparam logic [2:0] AddrMsip       = 3'b000;
  localparam logic [2:0] AddrSsip       = 3'b001;
  localparam logic [2:0] AddrMtimeLo    = 3'b010;
  localparam logic [2:0] AddrMtimeHi    = 3'b110;
  localparam logic [2:0] AddrMtimecmpLo = 3'b011;
  localparam logic [2:0] AddrMtimecmpHi = 3'b111;

  logic        clock;
  logic        reset;
  logic        a_rd_en;
  logic        a_wr_en;
  logic [2:0]  a_addr;
  logic [31:0] a_wr_data;
  logic [31:0] a_rd_data;
  logic        a_done;
  logic        b_rd_en;
  logic        b_wr_en;
  logic [2:0]  b_addr;
  logic [31:0] b_wr_data;
  logic [31:0] b_rd_data;
  logic        b_done;
  logic        msip_irq;
  logic        ssip_irq;
  logic        timer_irq;

  // Reference model
  logic [31:0] model_msip;
  logic [31:0] model_ssip;
  logic [63:0] model_mtimecmp;
  logic [31:0] mtime_lo_written;
  int          mtime_write_cycle;
  bit          last_b;

  int     cycle = 0;
  integer seed;
  logic   a_done_q = 1'b0;
  logic   b_done_q = 1'b0;

  clint_top clint_top_i (
    .clock     (clock),
    .reset     (reset),
    .a_rd_en   (a_rd_en),
    .a_wr_en   (a_wr_en),
    .a_addr    (a_addr),
    .a_wr_data (a_wr_data),
    .a_rd_data (a_rd_data),
    .a_done    (a_done),
    .b_rd_en   (b_rd_en),
    .b_wr_en   (b_wr_en),
    .b_addr    (b_addr),
    .b_wr_data (b_wr_data),
    .b_rd_data (b_rd_data),
    .b_done    (b_done),
    .msip_irq  (msip_irq),
    .ssip_irq  (ssip_irq),
    .timer_irq (timer_irq)
  );

  always #50 clock = ~clock;

  task stop_with_failure();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    $display("** Error at time %0t: %s expected 0x%0h, got 0x%0h", $time, name,
             expected, actual);
    stop_with_failure();
  endtask

  task automatic check_equal(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual === expected) else begin
      report_mismatch(name, expected, actual);
    end
  endtask

  task automatic check_range(input string name, input logic [63:0] low,
                             input logic [63:0] high, input logic [63:0] actual);
    assert (actual >= low && actual <= high) else begin
      $display("** Error at time %0t: %s expected %0d to %0d, got %0d", $time, name,
               low, high, actual);
      stop_with_failure();
    end
  endtask

  // Cycle count, timeout and done pulse shape
  always @(posedge clock) begin
    cycle    <= cycle + 1;
    a_done_q <= a_done;
    b_done_q <= b_done;
    if (cycle >= MaxCycles) begin
      $display("Timeout, the run did not finish within %0d cycles", MaxCycles);
      stop_with_failure();
    end
    if (!reset) begin
      assert (!(a_done && a_done_q)) else report_mismatch("a_done second cycle", 0, a_done);
      assert (!(b_done && b_done_q)) else report_mismatch("b_done second cycle", 0, b_done);
      assert (!a_done || a_rd_en || a_wr_en) else report_mismatch("a_done idle", 0, a_done);
      assert (!b_done || b_rd_en || b_wr_en) else report_mismatch("b_done idle", 0, b_done);
    end
  end

  // Holds one request until its done and reports the cycles in between
  task automatic run_access(input bit use_b, input bit is_read, input logic [2:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output int done_cycle, output int latency);
    int start_cycle;
    bit seen;
    @(posedge clock);
    if (use_b) begin
      b_rd_en   <= is_read;
      b_wr_en   <= !is_read;
      b_addr    <= addr;
      b_wr_data <= wdata;
    end else begin
      a_rd_en   <= is_read;
      a_wr_en   <= !is_read;
      a_addr    <= addr;
      a_wr_data <= wdata;
    end
    start_cycle = cycle;
    seen = 1'b0;
    while (!seen) begin
      @(posedge clock);
      seen = use_b ? b_done : a_done;
    end
    rdata      = use_b ? b_rd_data : a_rd_data;
    done_cycle = cycle;
    latency    = done_cycle - start_cycle;
    if (use_b) begin
      b_rd_en <= 1'b0;
      b_wr_en <= 1'b0;
    end else begin
      a_rd_en <= 1'b0;
      a_wr_en <= 1'b0;
    end
  endtask

  task automatic update_model(input logic [2:0] addr, input logic [31:0] data,
                              input int done_cycle);
    case (addr)
      AddrMsip:       model_msip = data;
      AddrSsip:       model_ssip = data;
      AddrMtimecmpLo: model_mtimecmp[31:0] = data;
      AddrMtimecmpHi: model_mtimecmp[63:32] = data;
      AddrMtimeLo: begin
        mtime_lo_written  = data;
        mtime_write_cycle = done_cycle;
      end
      default: ;
    endcase
  endtask

  task automatic write_reg(input bit use_b, input logic [2:0] addr, input logic [31:0] data);
    logic [31:0] ignored;
    int done_cycle;
    int latency;
    run_access(use_b, 1'b0, addr, data, ignored, done_cycle, latency);
    check_equal(use_b ? "b_done latency" : "a_done latency", 2, latency);
    last_b = use_b;
    update_model(addr, data, done_cycle);
    check_equal("msip_irq", model_msip[0], msip_irq);
    check_equal("ssip_irq", model_ssip[0], ssip_irq);
  endtask

  task automatic read_reg(input bit use_b, input logic [2:0] addr, output logic [31:0] data,
                          output int done_cycle);
    int latency;
    run_access(use_b, 1'b1, addr, 32'd0, data, done_cycle, latency);
    check_equal(use_b ? "b_done latency" : "a_done latency", 2, latency);
    last_b = use_b;
  endtask

  task automatic read_and_check(input logic [2:0] addr, input logic [31:0] expected,
                                input string name);
    logic [31:0] data;
    int done_cycle;
    read_reg(1'b0, addr, data, done_cycle);
    check_equal(name, expected, data);
  endtask

  // A writes ssip while B reads it
  // The port not granted last wins
  task automatic contend_pair(input logic [31:0] value);
    logic [31:0] a_data;
    logic [31:0] b_data;
    logic [31:0] b_expected;
    int a_cycle;
    int b_cycle;
    int a_latency;
    int b_latency;
    bit a_first;
    a_first    = last_b;
    b_expected = a_first ? value : model_ssip;
    fork
      run_access(1'b0, 1'b0, AddrSsip, value, a_data, a_cycle, a_latency);
      run_access(1'b1, 1'b1, AddrSsip, 32'd0, b_data, b_cycle, b_latency);
    join
    if (a_first) begin
      check_equal("a_done latency", 2, a_latency);
      check_equal("b_done cycle", a_cycle + 2, b_cycle);
    end else begin
      check_equal("b_done latency", 2, b_latency);
      check_equal("a_done cycle", b_cycle + 2, a_cycle);
    end
    check_equal("b_rd_data", b_expected, b_data);
    model_ssip = value;
    last_b     = a_first;
    check_equal("ssip_irq", model_ssip[0], ssip_irq);
  endtask

  initial begin
    logic [31:0] value;
    logic [31:0] data;
    int          done_cycle;
    int          load_cycle;
    int          rise_cycle;
    seed           = 69;
    clock          = 1'b0;
    reset          = 1'b1;
    a_rd_en        = 1'b0;
    a_wr_en        = 1'b0;
    a_addr         = '0;
    a_wr_data      = '0;
    b_rd_en        = 1'b0;
    b_wr_en        = 1'b0;
    b_addr         = '0;
    b_wr_data      = '0;
    model_msip     = '0;
    model_ssip     = '0;
    model_mtimecmp = '0;
    last_b         = 1'b1;
    repeat (2) @(posedge clock);
    reset <= 1'b0;

    // After reset mtime 0 already reaches mtimecmp 0
    @(posedge clock);
    check_equal("a_done", 0, a_done);
    check_equal("b_done", 0, b_done);
    check_equal("a_rd_data", 0, a_rd_data);
    check_equal("b_rd_data", 0, b_rd_data);
    check_equal("msip_irq", 0, msip_irq);
    check_equal("ssip_irq", 0, ssip_irq);
    check_equal("timer_irq", 1, timer_irq);
    read_and_check(AddrMsip, 32'd0, "msip");
    read_and_check(AddrSsip, 32'd0, "ssip");
    read_and_check(AddrMtimecmpLo, 32'd0, "mtimecmp lo");
    read_and_check(AddrMtimecmpHi, 32'd0, "mtimecmp hi");

    // Software interrupt words through port A with bit 0 toggled each round
    for (int i = 0; i < 6; i++) begin
      value    = $random(seed);
      value[0] = i[0];
      write_reg(1'b0, AddrMsip, value);
      read_and_check(AddrMsip, model_msip, "msip");
      value    = $random(seed);
      value[0] = !i[0];
      write_reg(1'b0, AddrSsip, value);
      read_and_check(AddrSsip, model_ssip, "ssip");
    end

    // Half-word timer access
    write_reg(1'b0, AddrMtimecmpLo, $random(seed));
    write_reg(1'b0, AddrMtimecmpHi, $random(seed));
    read_and_check(AddrMtimecmpLo, model_mtimecmp[31:0], "mtimecmp lo");
    read_and_check(AddrMtimecmpHi, model_mtimecmp[63:32], "mtimecmp hi");
    write_reg(1'b0, AddrMtimeLo, $random(seed) & 32'h0fff_ffff);
    value = $random(seed);
    write_reg(1'b0, AddrMtimeHi, value);
    read_and_check(AddrMtimeHi, value, "mtime hi");
    read_reg(1'b0, AddrMtimeLo, data, done_cycle);
    check_range("mtime lo", mtime_lo_written,
                mtime_lo_written + (done_cycle - mtime_write_cycle) / TickCycles + 1, data);

    // Timer interrupt against mtimecmp 20
    write_reg(1'b0, AddrMtimecmpHi, 32'd0);
    write_reg(1'b0, AddrMtimecmpLo, 32'd20);
    write_reg(1'b0, AddrMtimeHi, 32'd0);
    write_reg(1'b0, AddrMtimeLo, 32'd0);
    load_cycle = mtime_write_cycle - 1;
    check_equal("timer_irq", 0, timer_irq);
    while (!timer_irq) begin
      @(posedge clock);
    end
    rise_cycle = cycle;
    check_range("timer_irq rise cycles after load", 20 * TickCycles - TickCycles,
                20 * TickCycles + TickCycles, rise_cycle - load_cycle);
    repeat (2 * TickCycles) begin
      @(posedge clock);
      check_equal("timer_irq", 1, timer_irq);
    end
    write_reg(1'b0, AddrMtimecmpLo, 32'd1000);
    check_equal("timer_irq", 0, timer_irq);

    // A solo B access first so that A wins the first contended pair
    read_reg(1'b1, AddrMsip, data, done_cycle);
    check_equal("b_rd_data", model_msip, data);
    for (int i = 0; i < 4; i++) begin
      if (i[0]) begin
        write_reg(1'b0, AddrMsip, $random(seed));
      end
      contend_pair($random(seed));
    end

    repeat (2) @(posedge clock);
    $display("Everything OK");
    $finish;
  end

endmodule

// ==== logic/clint_top.sv ====
`include "clint_settings.svh"

module clint_top (
  input  logic                     clock,
  input  logic                     reset,
  // Hart load/store port
  input  logic                     a_rd_en,
  input  logic                     a_wr_en,
  input  logic [2:0]               a_addr,
  input  logic [`CLINT_DATA_W-1:0] a_wr_data,
  output logic [`CLINT_DATA_W-1:0] a_rd_data,
  output logic                     a_done,
  // Debug/host port
  input  logic                     b_rd_en,
  input  logic                     b_wr_en,
  input  logic [2:0]               b_addr,
  input  logic [`CLINT_DATA_W-1:0] b_wr_data,
  output logic [`CLINT_DATA_W-1:0] b_rd_data,
  output logic                     b_done,
  // Interrupt lines
  output logic                     msip_irq,
  output logic                     ssip_irq,
  output logic                     timer_irq
);

  clint_bus_if bus ();

  clint_arbiter arbiter_i (
    .clock     (clock),
    .reset     (reset),
    .a_rd_en   (a_rd_en),
    .a_wr_en   (a_wr_en),
    .a_addr    (a_addr),
    .a_wr_data (a_wr_data),
    .b_rd_en   (b_rd_en),
    .b_wr_en   (b_wr_en),
    .b_addr    (b_addr),
    .b_wr_data (b_wr_data),
    .a_rd_data (a_rd_data),
    .b_rd_data (b_rd_data),
    .a_done    (a_done),
    .b_done    (b_done),
    .bus       (bus.requester)
  );

  clint_regs regs_i (
    .clock     (clock),
    .reset     (reset),
    .bus       (bus.responder),
    .msip_irq  (msip_irq),
    .ssip_irq  (ssip_irq),
    .timer_irq (timer_irq)
  );

endmodule

// ==== logic/clint_regs.sv ====
`include "clint_settings.svh"

module clint_regs (
  input  logic           clock,
  input  logic           reset,
  clint_bus_if.responder bus,
  output logic           msip_irq,
  output logic           ssip_irq,
  output logic           timer_irq
);

  clint_pkg::reg_sel_t      sel;
  logic [`CLINT_DATA_W-1:0] msip;
  logic [`CLINT_DATA_W-1:0] ssip;
  clint_pkg::timer_word_t   mtime;
  clint_pkg::timer_word_t   mtimecmp;
  logic                     mtime_wr;
  logic                     mtimecmp_wr;
  logic                     hi_half;
  logic                     busy;

  assign sel     = clint_pkg::reg_sel_t'(bus.addr[1:0]);
  assign hi_half = bus.addr[2];

  assign mtime_wr    = bus.wr_en && (sel == clint_pkg::SEL_MTIME);
  assign mtimecmp_wr = bus.wr_en && (sel == clint_pkg::SEL_MTIMECMP);

  // Software interrupt words
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      msip <= '0;
      ssip <= '0;
    end else if (bus.wr_en) begin
      if (sel == clint_pkg::SEL_MSIP) begin
        msip <= bus.wr_data;
      end
      if (sel == clint_pkg::SEL_SSIP) begin
        ssip <= bus.wr_data;
      end
    end
  end

  assign msip_irq = msip[0];
  assign ssip_irq = ssip[0];

  clint_timer timer_i (
    .clock       (clock),
    .reset       (reset),
    .mtime_wr    (mtime_wr),
    .mtimecmp_wr (mtimecmp_wr),
    .hi_half     (hi_half),
    .wr_data     (bus.wr_data),
    .mtime       (mtime),
    .mtimecmp    (mtimecmp),
    .timer_irq   (timer_irq)
  );

  // Read mux, timer words by half
  always_comb begin
    case (sel)
      clint_pkg::SEL_MSIP: begin
        bus.rd_data = msip;
      end
      clint_pkg::SEL_SSIP: begin
        bus.rd_data = ssip;
      end
      clint_pkg::SEL_MTIME: begin
        bus.rd_data = hi_half ? mtime.half.hi : mtime.half.lo;
      end
      default: begin
        bus.rd_data = hi_half ? mtimecmp.half.hi : mtimecmp.half.lo;
      end
    endcase
  end

  // One cycle of busy after every access
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      busy <= 1'b0;
    end else if (busy) begin
      busy <= 1'b0;
    end else if (bus.rd_en || bus.wr_en) begin
      busy <= 1'b1;
    end
  end

  assign bus.busy = busy;

endmodule

// ==== logic/clint_timer.sv ====
`include "clint_settings.svh"

module clint_timer (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     mtime_wr,
  input  logic                     mtimecmp_wr,
  input  logic                     hi_half,
  input  logic [`CLINT_DATA_W-1:0] wr_data,
  output clint_pkg::timer_word_t   mtime,
  output clint_pkg::timer_word_t   mtimecmp,
  output logic                     timer_irq
);

  localparam int TickCycles = `CLINT_TICK_CYCLES;
  localparam int PrescW     = (TickCycles > 1) ? $clog2(TickCycles) : 1;

  logic [PrescW-1:0] prescaler;
  logic              tick;

  assign tick = (prescaler == PrescW'(TickCycles - 1));

  // Prescaler wraps on tick
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      prescaler <= '0;
    end else if (tick) begin
      prescaler <= '0;
    end else begin
      prescaler <= prescaler + 1'b1;
    end
  end

  // Bus load wins over the increment, other half is kept
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mtime <= '0;
    end else if (mtime_wr) begin
      if (hi_half) begin
        mtime.half.hi <= wr_data;
      end else begin
        mtime.half.lo <= wr_data;
      end
    end else if (tick) begin
      mtime.count <= mtime.count + 64'd1;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mtimecmp <= '0;
    end else if (mtimecmp_wr) begin
      if (hi_half) begin
        mtimecmp.half.hi <= wr_data;
      end else begin
        mtimecmp.half.lo <= wr_data;
      end
    end
  end

  // Pending while the count has reached the compare value
  assign timer_irq = (mtime.count >= mtimecmp.count);

endmodule

// ==== logic/clint_arbiter.sv ====
`include "clint_settings.svh"

module clint_arbiter (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     a_rd_en,
  input  logic                     a_wr_en,
  input  logic [2:0]               a_addr,
  input  logic [`CLINT_DATA_W-1:0] a_wr_data,
  input  logic                     b_rd_en,
  input  logic                     b_wr_en,
  input  logic [2:0]               b_addr,
  input  logic [`CLINT_DATA_W-1:0] b_wr_data,
  output logic [`CLINT_DATA_W-1:0] a_rd_data,
  output logic [`CLINT_DATA_W-1:0] b_rd_data,
  output logic                     a_done,
  output logic                     b_done,
  clint_bus_if.requester           bus
);

  logic a_req;
  logic b_req;
  logic grant_a;
  logic grant_b;
  logic last_a;

  // A port finishing this cycle still holds its request, ignore it
  assign a_req = (a_rd_en | a_wr_en) & ~a_done;
  assign b_req = (b_rd_en | b_wr_en) & ~b_done;

  // Round robin, A wins ties after reset
  assign grant_a = ~bus.busy & a_req & (~b_req | ~last_a);
  assign grant_b = ~bus.busy & b_req & ~grant_a;

  // Strobes only for the granted port
  always_comb begin
    bus.rd_en = 1'b0;
    bus.wr_en = 1'b0;
    if (grant_a) begin
      bus.rd_en = a_rd_en;
      bus.wr_en = a_wr_en;
    end else if (grant_b) begin
      bus.rd_en = b_rd_en;
      bus.wr_en = b_wr_en;
    end
  end

  assign bus.addr    = grant_b ? b_addr : a_addr;
  assign bus.wr_data = grant_b ? b_wr_data : a_wr_data;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      a_done <= 1'b0;
      b_done <= 1'b0;
      last_a <= 1'b0;
    end else begin
      a_done <= grant_a;
      b_done <= grant_b;
      if (grant_a) begin
        last_a <= 1'b1;
      end else if (grant_b) begin
        last_a <= 1'b0;
      end
    end
  end

  // Read data is sampled on the grant edge and held until the port's next access
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      a_rd_data <= '0;
      b_rd_data <= '0;
    end else begin
      if (grant_a) begin
        a_rd_data <= bus.rd_data;
      end
      if (grant_b) begin
        b_rd_data <= bus.rd_data;
      end
    end
  end

endmodule

// ==== logic/clint_bus_if.sv ====
`include "clint_settings.svh"

interface clint_bus_if;

  logic                     rd_en;
  logic                     wr_en;
  logic [2:0]               addr;
  logic [`CLINT_DATA_W-1:0] wr_data;
  logic [`CLINT_DATA_W-1:0] rd_data;
  logic                     busy;

  // Arbiter side
  modport requester (
    output rd_en,
    output wr_en,
    output addr,
    output wr_data,
    input  rd_data,
    input  busy
  );

  // Register block side
  modport responder (
    input  rd_en,
    input  wr_en,
    input  addr,
    input  wr_data,
    output rd_data,
    output busy
  );

endinterface

// ==== logic/clint_pkg.sv ====
`include "clint_settings.svh"

package clint_pkg;

  // Register chosen by addr[1:0]
  typedef enum logic [1:0] {
    SEL_MSIP     = 2'b00,
    SEL_SSIP     = 2'b01,
    SEL_MTIME    = 2'b10,
    SEL_MTIMECMP = 2'b11
  } reg_sel_t;

  // Two bus words make one timer word, addr[2] picks hi
  typedef struct packed {
    logic [`CLINT_DATA_W-1:0] hi;
    logic [`CLINT_DATA_W-1:0] lo;
  } timer_halves_t;

  // Whole count for the counter and compare, halves for the bus side
  typedef union packed {
    logic [63:0]   count;
    timer_halves_t half;
  } timer_word_t;

endpackage

// ==== logic/clint_settings.svh ====
`ifndef CLINT_SETTINGS_SVH
`define CLINT_SETTINGS_SVH

// Register bus data width
`define CLINT_DATA_W 32

// Clocks per mtime increment, kept short for simulation
`define CLINT_TICK_CYCLES 4

`endif
